//--- hw/action_pkg.sv
package action_pkg;

    // PHV layout
    parameter int PHV_LEN  = 1024;
    parameter int VLAN_W   = 12;
    parameter int VLAN_LSB = 129;

    // control stream widths
    parameter int CTRL_DATA_W = 256;
    parameter int CTRL_USER_W = 128;
    parameter int CTRL_KEEP_W = CTRL_DATA_W / 8;

    // fields inside a control segment
    parameter int MOD_ID_LSB    = 112;
    parameter int CFG_FLAG_LSB  = 64;
    parameter int CFG_INDEX_LSB = 128;

    // udp port value marking a configuration packet
    parameter logic [15:0] CFG_FLAG = 16'hf2f1;

    // page table geometry
    parameter int PAGE_W        = 16;
    parameter int PAGE_DEPTH    = 32;
    parameter int PAGE_ADDR_W   = 5;
    parameter int PAGE_ADDR_LSB = 4;

    typedef logic [PHV_LEN-1:0]     phv_t;
    typedef logic [VLAN_W-1:0]      vlan_id_t;
    typedef logic [PAGE_W-1:0]      page_entry_t;
    typedef logic [PAGE_ADDR_W-1:0] page_addr_t;

    typedef logic [CTRL_DATA_W-1:0] ctrl_data_t;
    typedef logic [CTRL_USER_W-1:0] ctrl_user_t;
    typedef logic [CTRL_KEEP_W-1:0] ctrl_keep_t;

    // only the low bits address the table
    typedef logic [7:0]             cfg_index_t;

endpackage

//--- hw/ctrl_cfg_filter.sv
module ctrl_cfg_filter #(
    parameter logic [4:0] STAGE_ID  = 5'd0,
    parameter logic [2:0] ACTION_ID = 3'd0
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  action_pkg::ctrl_data_t  c_s_tdata_i,
    input  action_pkg::ctrl_user_t  c_s_tuser_i,
    input  action_pkg::ctrl_keep_t  c_s_tkeep_i,
    input  logic                    c_s_tvalid_i,
    input  logic                    c_s_tlast_i,

    output action_pkg::ctrl_data_t  c_m_tdata_o,
    output action_pkg::ctrl_user_t  c_m_tuser_o,
    output action_pkg::ctrl_keep_t  c_m_tkeep_o,
    output logic                    c_m_tvalid_o,
    output logic                    c_m_tlast_o,

    output logic                    wr_en_o,
    output action_pkg::page_addr_t  wr_addr_o,
    output action_pkg::page_entry_t wr_data_o
);
    import action_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_PARSE,
        S_ENTRY,
        S_FLUSH,
        S_DROP
    } state_t;

    state_t state;
    state_t state_nxt;

    // first segment, held until the second one decides
    ctrl_data_t first_tdata;
    ctrl_user_t first_tuser;
    ctrl_keep_t first_tkeep;
    logic       first_tlast;

    // input stream delayed by one cycle
    ctrl_data_t d1_tdata;
    ctrl_user_t d1_tuser;
    ctrl_keep_t d1_tkeep;
    logic       d1_tvalid;
    logic       d1_tlast;

    logic [7:0]  mod_id;
    logic [15:0] ctrl_flag;
    cfg_index_t  cfg_index;
    logic        cfg_match;
    ctrl_data_t  tdata_swapped;

    logic hold_first;
    logic capture_index;
    logic capture_entry;
    logic emit_first;
    logic emit_d1;

    // little endian segment to big endian
    function automatic ctrl_data_t byte_swap(input ctrl_data_t din);
        ctrl_data_t dout;
        for (int i = 0; i < CTRL_KEEP_W; i++) begin
            dout[i*8 +: 8] = din[(CTRL_KEEP_W-1-i)*8 +: 8];
        end
        return dout;
    endfunction

    assign mod_id        = c_s_tdata_i[MOD_ID_LSB +: 8];
    assign ctrl_flag     = c_s_tdata_i[CFG_FLAG_LSB +: $bits(CFG_FLAG)];
    assign cfg_index     = c_s_tdata_i[CFG_INDEX_LSB +: $bits(cfg_index_t)];
    assign tdata_swapped = byte_swap(c_s_tdata_i);

    // stage in the upper five bits, action in the lower three
    assign cfg_match = (mod_id[7:3] == STAGE_ID) && (mod_id[2:0] == ACTION_ID) &&
                       (ctrl_flag == CFG_FLAG);

    always_comb begin
        state_nxt     = state;
        hold_first    = 1'b0;
        capture_index = 1'b0;
        capture_entry = 1'b0;
        emit_first    = 1'b0;
        emit_d1       = 1'b0;
        case (state)
            S_IDLE: begin
                if (c_s_tvalid_i) begin
                    hold_first = 1'b1;
                    state_nxt  = S_PARSE;
                end
            end
            S_PARSE: begin
                if (c_s_tvalid_i && cfg_match) begin
                    capture_index = 1'b1;
                    state_nxt     = S_ENTRY;
                end else if (c_s_tvalid_i) begin
                    emit_first = 1'b1;
                    state_nxt  = S_FLUSH;
                end
            end
            S_ENTRY: begin
                if (c_s_tvalid_i) begin
                    capture_entry = 1'b1;
                    state_nxt     = c_s_tlast_i ? S_IDLE : S_DROP;
                end
            end
            S_FLUSH: begin
                emit_d1 = 1'b1;
                if (d1_tvalid && d1_tlast) begin
                    state_nxt = S_IDLE;
                    // back to back packet starts right here
                    if (c_s_tvalid_i) begin
                        hold_first = 1'b1;
                        state_nxt  = S_PARSE;
                    end
                end
            end
            S_DROP: begin
                if (c_s_tvalid_i && c_s_tlast_i) begin
                    state_nxt = S_IDLE;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            d1_tvalid    <= 1'b0;
            d1_tlast     <= 1'b0;
            c_m_tvalid_o <= 1'b0;
            c_m_tlast_o  <= 1'b0;
            wr_en_o      <= 1'b0;
        end else begin
            state        <= state_nxt;
            d1_tvalid    <= c_s_tvalid_i;
            d1_tlast     <= c_s_tlast_i;
            c_m_tvalid_o <= emit_first || (emit_d1 && d1_tvalid);
            c_m_tlast_o  <= emit_first ? first_tlast : (emit_d1 && d1_tvalid && d1_tlast);
            wr_en_o      <= capture_entry;
        end
    end

    always_ff @(posedge clk) begin
        d1_tdata <= c_s_tdata_i;
        d1_tuser <= c_s_tuser_i;
        d1_tkeep <= c_s_tkeep_i;
        if (hold_first) begin
            first_tdata <= c_s_tdata_i;
            first_tuser <= c_s_tuser_i;
            first_tkeep <= c_s_tkeep_i;
            first_tlast <= c_s_tlast_i;
        end
        c_m_tdata_o <= emit_first ? first_tdata : d1_tdata;
        c_m_tuser_o <= emit_first ? first_tuser : d1_tuser;
        c_m_tkeep_o <= emit_first ? first_tkeep : d1_tkeep;
        if (capture_index) begin
            wr_addr_o <= cfg_index[PAGE_ADDR_W-1:0];
        end
        if (capture_entry) begin
            wr_data_o <= tdata_swapped[CTRL_DATA_W-1 -: PAGE_W];
        end
    end

endmodule

//--- hw/page_table.sv
module page_table (
    input  logic                    clk,
    input  logic                    wr_en_i,
    input  action_pkg::page_addr_t  wr_addr_i,
    input  action_pkg::page_entry_t wr_data_i,
    input  action_pkg::page_addr_t  rd_addr_i,
    output action_pkg::page_entry_t rd_data_o
);
    import action_pkg::*;

    page_entry_t mem [PAGE_DEPTH];

    // same-address read and write returns the old entry
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

//--- hw/vlan_page_lookup.sv
module vlan_page_lookup (
    input  logic                    clk,
    input  logic                    rst_n,

    input  action_pkg::vlan_id_t    act_vlan_i,
    input  logic                    act_vlan_valid_i,
    output logic                    act_vlan_ready_o,

    output action_pkg::page_addr_t  rd_addr_o,
    input  action_pkg::page_entry_t rd_data_i,

    output action_pkg::page_entry_t page_o,
    output logic                    page_valid_o
);
    import action_pkg::*;

    typedef enum logic {
        L_IDLE,
        L_BUSY
    } lk_state_t;

    lk_state_t   state;
    logic        accept;
    logic        rd_pend;
    logic        entry_vld;
    page_entry_t entry_q;

    assign act_vlan_ready_o = (state == L_IDLE);
    assign accept           = act_vlan_valid_i && act_vlan_ready_o;

    // accept, table read, capture, present
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= L_IDLE;
            rd_pend      <= 1'b0;
            entry_vld    <= 1'b0;
            page_valid_o <= 1'b0;
        end else begin
            rd_pend <= 1'b0;
            case (state)
                L_IDLE: begin
                    if (accept) begin
                        state <= L_BUSY;
                    end
                end
                default: begin
                    state   <= L_IDLE;
                    rd_pend <= 1'b1;
                end
            endcase
            entry_vld    <= rd_pend;
            page_valid_o <= entry_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_addr_o <= act_vlan_i[PAGE_ADDR_LSB +: PAGE_ADDR_W];
        end
        if (rd_pend) begin
            entry_q <= rd_data_i;
        end
        if (entry_vld) begin
            page_o <= entry_q;
        end
    end

endmodule

//--- hw/phv_vlan_tap.sv
module phv_vlan_tap (
    input  logic                 clk,
    input  logic                 rst_n,

    input  action_pkg::phv_t     phv_i,
    input  logic                 phv_valid_i,

    output action_pkg::vlan_id_t vlan_o,
    output logic                 vlan_valid_o,
    input  logic                 vlan_ready_i
);
    import action_pkg::*;

    typedef enum logic {
        T_IDLE,
        T_FLUSH
    } tap_state_t;

    tap_state_t state;
    vlan_id_t   vlan_q;
    logic       vlan_vld_q;

    // phv pulses in flush are ignored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= T_IDLE;
            vlan_vld_q   <= 1'b0;
            vlan_valid_o <= 1'b0;
        end else begin
            vlan_vld_q <= 1'b0;
            case (state)
                T_IDLE: begin
                    if (phv_valid_i) begin
                        state <= T_FLUSH;
                    end
                end
                default: begin
                    if (vlan_ready_i) begin
                        vlan_vld_q <= 1'b1;
                        state      <= T_IDLE;
                    end
                end
            endcase
            vlan_valid_o <= vlan_vld_q;
        end
    end

    always_ff @(posedge clk) begin
        if (state == T_IDLE && phv_valid_i) begin
            vlan_q <= phv_i[VLAN_LSB +: VLAN_W];
        end
        // extra output stage
        if (vlan_vld_q) begin
            vlan_o <= vlan_q;
        end
    end

endmodule

//--- hw/action_engine.sv
module action_engine #(
    parameter logic [4:0] STAGE_ID  = 5'd0,
    parameter logic [2:0] ACTION_ID = 3'd0
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // control stream in
    input  action_pkg::ctrl_data_t  c_s_tdata_i,
    input  action_pkg::ctrl_user_t  c_s_tuser_i,
    input  action_pkg::ctrl_keep_t  c_s_tkeep_i,
    input  logic                    c_s_tvalid_i,
    input  logic                    c_s_tlast_i,

    // control stream out
    output action_pkg::ctrl_data_t  c_m_tdata_o,
    output action_pkg::ctrl_user_t  c_m_tuser_o,
    output action_pkg::ctrl_keep_t  c_m_tkeep_o,
    output logic                    c_m_tvalid_o,
    output logic                    c_m_tlast_o,

    // page lookup
    input  action_pkg::vlan_id_t    act_vlan_i,
    input  logic                    act_vlan_valid_i,
    output logic                    act_vlan_ready_o,
    output action_pkg::page_entry_t page_o,
    output logic                    page_valid_o,

    // vlan tap
    input  action_pkg::phv_t        phv_i,
    input  logic                    phv_valid_i,
    output action_pkg::vlan_id_t    vlan_o,
    output logic                    vlan_valid_o,
    input  logic                    vlan_ready_i
);
    import action_pkg::*;

    logic        tbl_wr_en;
    page_addr_t  tbl_wr_addr;
    page_entry_t tbl_wr_data;
    page_addr_t  tbl_rd_addr;
    page_entry_t tbl_rd_data;

    ctrl_cfg_filter #(
        .STAGE_ID  (STAGE_ID),
        .ACTION_ID (ACTION_ID)
    ) u_ctrl_cfg_filter (
        .clk          (clk),
        .rst_n        (rst_n),
        .c_s_tdata_i  (c_s_tdata_i),
        .c_s_tuser_i  (c_s_tuser_i),
        .c_s_tkeep_i  (c_s_tkeep_i),
        .c_s_tvalid_i (c_s_tvalid_i),
        .c_s_tlast_i  (c_s_tlast_i),
        .c_m_tdata_o  (c_m_tdata_o),
        .c_m_tuser_o  (c_m_tuser_o),
        .c_m_tkeep_o  (c_m_tkeep_o),
        .c_m_tvalid_o (c_m_tvalid_o),
        .c_m_tlast_o  (c_m_tlast_o),
        .wr_en_o      (tbl_wr_en),
        .wr_addr_o    (tbl_wr_addr),
        .wr_data_o    (tbl_wr_data)
    );

    page_table u_page_table (
        .clk       (clk),
        .wr_en_i   (tbl_wr_en),
        .wr_addr_i (tbl_wr_addr),
        .wr_data_i (tbl_wr_data),
        .rd_addr_i (tbl_rd_addr),
        .rd_data_o (tbl_rd_data)
    );

    vlan_page_lookup u_vlan_page_lookup (
        .clk              (clk),
        .rst_n            (rst_n),
        .act_vlan_i       (act_vlan_i),
        .act_vlan_valid_i (act_vlan_valid_i),
        .act_vlan_ready_o (act_vlan_ready_o),
        .rd_addr_o        (tbl_rd_addr),
        .rd_data_i        (tbl_rd_data),
        .page_o           (page_o),
        .page_valid_o     (page_valid_o)
    );

    phv_vlan_tap u_phv_vlan_tap (
        .clk          (clk),
        .rst_n        (rst_n),
        .phv_i        (phv_i),
        .phv_valid_i  (phv_valid_i),
        .vlan_o       (vlan_o),
        .vlan_valid_o (vlan_valid_o),
        .vlan_ready_i (vlan_ready_i)
    );

endmodule

//--- tb/action_engine_asserts.sv
module action_engine_asserts (
    input  logic clk,
    input  logic rst_n,
    input  logic c_m_tvalid_i,
    input  logic act_vlan_valid_i,
    input  logic act_vlan_ready_i,
    input  logic page_valid_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // forwarded stream stays quiet while in reset
    assert property (@(posedge clk) !rst_n |-> !c_m_tvalid_i)
        else begin
            $error("c_m_tvalid_o high during reset");
            fail_count++;
        end

    // page valid is a single cycle pulse
    assert property (@(posedge clk) disable iff (!rst_n) page_valid_i |=> !page_valid_i)
        else begin
            $error("page_valid_o high on two consecutive cycles");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        (act_vlan_valid_i && act_vlan_ready_i) |=> !act_vlan_ready_i)
        else begin
            $error("act_vlan_ready_o high in the cycle after an accepted request");
            fail_count++;
        end

endmodule

bind action_engine action_engine_asserts u_asserts (
    .clk              (clk),
    .rst_n            (rst_n),
    .c_m_tvalid_i     (c_m_tvalid_o),
    .act_vlan_valid_i (act_vlan_valid_i),
    .act_vlan_ready_i (act_vlan_ready_o),
    .page_valid_i     (page_valid_o)
);

//--- tb/tb_action_engine.sv
module tb_action_engine;
    timeunit 1ns;
    timeprecision 100ps;

    import action_pkg::*;

    localparam logic [4:0] STAGE_ID    = 5'd3;
    localparam logic [2:0] ACTION_ID   = 3'd5;
    localparam int         RESET_CYCLES = 8;

    typedef enum logic [1:0] {
        K_CFG,
        K_FOREIGN,
        K_LOOKUP,
        K_PHV
    } kind_t;

    // key is the table index for control rows, the vlan id otherwise
    typedef struct packed {
        kind_t       kind;
        logic [2:0]  segs;
        logic [7:0]  mod_id;
        logic [15:0] flag;
        logic [11:0] key;
        logic [15:0] entry;
        logic [3:0]  ready_low;
        logic        second_phv;
    } row_t;

    logic        clk;
    logic        rst_n;
    ctrl_data_t  c_s_tdata_i;
    ctrl_user_t  c_s_tuser_i;
    ctrl_keep_t  c_s_tkeep_i;
    logic        c_s_tvalid_i;
    logic        c_s_tlast_i;
    ctrl_data_t  c_m_tdata_o;
    ctrl_user_t  c_m_tuser_o;
    ctrl_keep_t  c_m_tkeep_o;
    logic        c_m_tvalid_o;
    logic        c_m_tlast_o;
    vlan_id_t    act_vlan_i;
    logic        act_vlan_valid_i;
    logic        act_vlan_ready_o;
    page_entry_t page_o;
    logic        page_valid_o;
    phv_t        phv_i;
    logic        phv_valid_i;
    vlan_id_t    vlan_o;
    logic        vlan_valid_o;
    logic        vlan_ready_i;

    row_t        rows[$];
    ctrl_data_t  fwd_data[$];
    ctrl_user_t  fwd_user[$];
    ctrl_keep_t  fwd_keep[$];
    logic        fwd_last[$];
    page_entry_t model[32];
    logic        model_valid[32];
    logic [31:0] lfsr_state;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count;
    int          limit;

    action_engine #(
        .STAGE_ID  (STAGE_ID),
        .ACTION_ID (ACTION_ID)
    ) DUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .c_s_tdata_i      (c_s_tdata_i),
        .c_s_tuser_i      (c_s_tuser_i),
        .c_s_tkeep_i      (c_s_tkeep_i),
        .c_s_tvalid_i     (c_s_tvalid_i),
        .c_s_tlast_i      (c_s_tlast_i),
        .c_m_tdata_o      (c_m_tdata_o),
        .c_m_tuser_o      (c_m_tuser_o),
        .c_m_tkeep_o      (c_m_tkeep_o),
        .c_m_tvalid_o     (c_m_tvalid_o),
        .c_m_tlast_o      (c_m_tlast_o),
        .act_vlan_i       (act_vlan_i),
        .act_vlan_valid_i (act_vlan_valid_i),
        .act_vlan_ready_o (act_vlan_ready_o),
        .page_o           (page_o),
        .page_valid_o     (page_valid_o),
        .phv_i            (phv_i),
        .phv_valid_i      (phv_valid_i),
        .vlan_o           (vlan_o),
        .vlan_valid_o     (vlan_valid_o),
        .vlan_ready_i     (vlan_ready_i)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (limit > 0 && cycle_count > limit) begin
            $display("test timed out after %0d cycles", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    // forwarded segments, sampled mid cycle
    always @(negedge clk) begin
        if (rst_n && c_m_tvalid_o) begin
            fwd_data.push_back(c_m_tdata_o);
            fwd_user.push_back(c_m_tuser_o);
            fwd_keep.push_back(c_m_tkeep_o);
            fwd_last.push_back(c_m_tlast_o);
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hb4bc_d35c) : (s >> 1);
    endfunction

    function logic random_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    function phv_t random_bits(input int n);
        phv_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = random_bit();
        end
        return v;
    endfunction

    function automatic logic is_config(input logic [7:0] mod_id, input logic [15:0] flag);
        return (mod_id[7:3] == STAGE_ID) && (mod_id[2:0] == ACTION_ID) && (flag == 16'hf2f1);
    endfunction

    function automatic string kind_name(input kind_t k);
        case (k)
            K_CFG:     return "config";
            K_FOREIGN: return "foreign";
            K_LOOKUP:  return "lookup";
            default:   return "phv";
        endcase
    endfunction

    task automatic add_row(input kind_t kind, input int segs, input logic [7:0] mod_id,
                           input logic [15:0] flag, input logic [11:0] key,
                           input logic [15:0] entry, input int ready_low,
                           input logic second_phv);
        row_t r;
        r.kind       = kind;
        r.segs       = segs[2:0];
        r.mod_id     = mod_id;
        r.flag       = flag;
        r.key        = key;
        r.entry      = entry;
        r.ready_low  = ready_low[3:0];
        r.second_phv = second_phv;
        rows.push_back(r);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        test_errors++;
    endtask

    task automatic check_data(input string name, input ctrl_data_t exp, input ctrl_data_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_user(input string name, input ctrl_user_t exp, input ctrl_user_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_keep(input string name, input ctrl_keep_t exp, input ctrl_keep_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_page(input string name, input page_entry_t exp,
                              input page_entry_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_vlan(input string name, input vlan_id_t exp, input vlan_id_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        if (test_errors == 0) begin
            $display("test %0d %s: ok", num, name);
            tests_passed++;
        end else begin
            $display("test %0d %s: %0d errors", num, name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic run_ctrl(input row_t r);
        ctrl_data_t seg_data[4];
        ctrl_user_t seg_user[4];
        ctrl_keep_t seg_keep[4];
        phv_t       tmp;
        logic       cfg;
        int         n;
        cfg = is_config(r.mod_id, r.flag) && (r.segs >= 3);
        n   = int'(r.segs);
        for (int i = 0; i < 4; i++) begin
            tmp         = random_bits(CTRL_DATA_W);
            seg_data[i] = tmp[CTRL_DATA_W-1:0];
            tmp         = random_bits(CTRL_USER_W);
            seg_user[i] = tmp[CTRL_USER_W-1:0];
            tmp         = random_bits(CTRL_KEEP_W);
            seg_keep[i] = tmp[CTRL_KEEP_W-1:0];
        end
        seg_data[1][119:112] = r.mod_id;
        seg_data[1][79:64]   = r.flag;
        seg_data[1][135:128] = r.key[7:0];
        // byte 0 carries the upper entry byte
        seg_data[2][7:0]  = r.entry[15:8];
        seg_data[2][15:8] = r.entry[7:0];
        fwd_data.delete();
        fwd_user.delete();
        fwd_keep.delete();
        fwd_last.delete();
        for (int i = 0; i < n; i++) begin
            c_s_tdata_i  = seg_data[i];
            c_s_tuser_i  = seg_user[i];
            c_s_tkeep_i  = seg_keep[i];
            c_s_tvalid_i = 1'b1;
            c_s_tlast_i  = (i == n - 1);
            next_cycle();
        end
        c_s_tvalid_i = 1'b0;
        c_s_tlast_i  = 1'b0;
        if (cfg) begin
            repeat (4) next_cycle();
            if (fwd_data.size() != 0) begin
                report_problem($sformatf("configuration packet forwarded %0d segments",
                                         fwd_data.size()));
            end
            model[r.key[4:0]]       = {seg_data[2][7:0], seg_data[2][15:8]};
            model_valid[r.key[4:0]] = 1'b1;
        end else begin
            while (fwd_data.size() < n) begin
                next_cycle();
            end
            repeat (3) next_cycle();
            if (fwd_data.size() != n) begin
                report_problem($sformatf("packet of %0d segments came out as %0d segments",
                                         n, fwd_data.size()));
            end else begin
                for (int i = 0; i < n; i++) begin
                    check_data($sformatf("c_m_tdata_o[%0d]", i), seg_data[i], fwd_data[i]);
                    check_user($sformatf("c_m_tuser_o[%0d]", i), seg_user[i], fwd_user[i]);
                    check_keep($sformatf("c_m_tkeep_o[%0d]", i), seg_keep[i], fwd_keep[i]);
                    check_last($sformatf("c_m_tlast_o[%0d]", i), i == n - 1, fwd_last[i]);
                end
            end
        end
    endtask

    task automatic run_lookup(input row_t r);
        logic [4:0]  addr;
        page_entry_t seen;
        logic        accepted;
        int          first;
        int          pulses;
        addr             = r.key[8:4];
        act_vlan_i       = r.key;
        act_vlan_valid_i = 1'b1;
        accepted         = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = act_vlan_ready_o;
            @(posedge clk);
        end
        #2;
        act_vlan_valid_i = 1'b0;
        first  = -1;
        pulses = 0;
        seen   = '0;
        // k counts edges after the accepting one
        for (int k = 0; k < 7; k++) begin
            @(negedge clk);
            if (k == 0 && act_vlan_ready_o) begin
                report_problem("request ready stayed high in the cycle after acceptance");
            end
            if (page_valid_o) begin
                pulses++;
                if (first < 0) begin
                    first = k;
                    seen  = page_o;
                end
            end
        end
        next_cycle();
        if (pulses != 1) begin
            report_problem($sformatf("lookup gave %0d page valid pulses instead of one", pulses));
        end else if (first != 3) begin
            report_problem($sformatf("page valid came %0d cycles after acceptance", first));
        end
        if (!model_valid[addr]) begin
            report_problem("lookup of a table address that was never written");
        end else begin
            check_page("page_o", model[addr], seen);
        end
    endtask

    task automatic run_phv(input row_t r);
        phv_t     phv;
        phv_t     phv2;
        vlan_id_t want;
        vlan_id_t seen;
        int       early;
        int       first;
        int       pulses;
        phv             = random_bits(PHV_LEN);
        phv[140:129]    = r.key;
        phv2            = random_bits(PHV_LEN);
        phv2[140:129]   = ~r.key;
        want            = phv[140:129];
        vlan_ready_i    = 1'b0;
        phv_i           = phv;
        phv_valid_i     = 1'b1;
        next_cycle();
        phv_valid_i = 1'b0;
        early       = 0;
        for (int i = 0; i < int'(r.ready_low); i++) begin
            if (r.second_phv && i == 0) begin
                phv_i       = phv2;
                phv_valid_i = 1'b1;
            end
            @(negedge clk);
            if (vlan_valid_o) begin
                early++;
            end
            next_cycle();
            phv_valid_i = 1'b0;
        end
        vlan_ready_i = 1'b1;
        first  = -1;
        pulses = 0;
        seen   = '0;
        for (int k = 0; k < 6; k++) begin
            @(negedge clk);
            if (vlan_valid_o) begin
                pulses++;
                if (first < 0) begin
                    first = k;
                    seen  = vlan_o;
                end
            end
        end
        next_cycle();
        vlan_ready_i = 1'b0;
        if (early != 0) begin
            report_problem("vlan valid pulsed while the downstream ready was low");
        end
        if (pulses != 1) begin
            report_problem($sformatf("phv gave %0d vlan valid pulses instead of one", pulses));
        end else if (first != 2) begin
            report_problem($sformatf("vlan valid came %0d cycles after ready rose", first));
        end
        check_vlan("vlan_o", want, seen);
    endtask

    initial begin
        rst_n            = 1'b1;
        c_s_tdata_i      = '0;
        c_s_tuser_i      = '0;
        c_s_tkeep_i      = '0;
        c_s_tvalid_i     = 1'b0;
        c_s_tlast_i      = 1'b0;
        act_vlan_i       = '0;
        act_vlan_valid_i = 1'b0;
        phv_i            = '0;
        phv_valid_i      = 1'b0;
        vlan_ready_i     = 1'b0;
        lfsr_state       = 32'h28d9;
        cycle_count      = 0;
        limit            = 0;
        tests_passed     = 0;
        tests_failed     = 0;
        for (int i = 0; i < 32; i++) begin
            model_valid[i] = 1'b0;
        end

        //      kind       segs mod id  flag      key      entry     rdy 2nd
        add_row(K_CFG,     3,   8'h1d,  16'hf2f1, 12'h004, 16'hbeef, 0,  0);
        add_row(K_LOOKUP,  0,   8'h00,  16'h0000, 12'he47, 16'h0000, 0,  0);
        add_row(K_CFG,     4,   8'h1d,  16'hf2f1, 12'h033, 16'h1234, 0,  0);
        add_row(K_LOOKUP,  0,   8'h00,  16'h0000, 12'h535, 16'h0000, 0,  0);
        add_row(K_CFG,     3,   8'h1d,  16'hf2f1, 12'h01f, 16'ha5c3, 0,  0);
        // wrong stage, wrong action, wrong flag
        add_row(K_FOREIGN, 2,   8'h25,  16'hf2f1, 12'h004, 16'h5555, 0,  0);
        add_row(K_FOREIGN, 3,   8'h1a,  16'hf2f1, 12'h013, 16'h6666, 0,  0);
        add_row(K_FOREIGN, 4,   8'h1d,  16'hf2f2, 12'h01f, 16'h7777, 0,  0);
        add_row(K_LOOKUP,  0,   8'h00,  16'h0000, 12'h04a, 16'h0000, 0,  0);
        add_row(K_LOOKUP,  0,   8'h00,  16'h0000, 12'h13a, 16'h0000, 0,  0);
        add_row(K_LOOKUP,  0,   8'h00,  16'h0000, 12'h1f0, 16'h0000, 0,  0);
        add_row(K_CFG,     4,   8'h1d,  16'hf2f1, 12'h0e4, 16'h0f0f, 0,  0);
        add_row(K_LOOKUP,  0,   8'h00,  16'h0000, 12'h84b, 16'h0000, 0,  0);
        add_row(K_PHV,     0,   8'h00,  16'h0000, 12'habc, 16'h0000, 0,  0);
        add_row(K_PHV,     0,   8'h00,  16'h0000, 12'h5a3, 16'h0000, 4,  0);
        add_row(K_PHV,     0,   8'h00,  16'h0000, 12'h7e1, 16'h0000, 3,  1);

        foreach (rows[i]) begin
            limit += int'(rows[i].segs) + 20;
        end
        limit += RESET_CYCLES;

        // reset edge away from time zero
        #2;
        rst_n       = 1'b0;
        test_errors = 0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (c_m_tvalid_o !== 1'b0 || page_valid_o !== 1'b0 || vlan_valid_o !== 1'b0) begin
                report_problem("a valid output was not low during reset");
            end
            if (act_vlan_ready_o !== 1'b1) begin
                report_problem("request ready was not high during reset");
            end
            @(posedge clk);
        end
        #2;
        rst_n = 1'b1;
        finish_test(0, "reset");
        next_cycle();

        foreach (rows[i]) begin
            test_errors = 0;
            case (rows[i].kind)
                K_CFG, K_FOREIGN: run_ctrl(rows[i]);
                K_LOOKUP:         run_lookup(rows[i]);
                default:          run_phv(rows[i]);
            endcase
            finish_test(i + 1, kind_name(rows[i].kind));
        end

        test_errors = 0;
        if (DUT.u_asserts.fail_count != 0) begin
            report_problem($sformatf("%0d assertion failures during the run",
                                     DUT.u_asserts.fail_count));
        end
        finish_test(rows.size() + 1, "assertions");

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- action_engine.f
hw/action_pkg.sv
hw/ctrl_cfg_filter.sv
hw/page_table.sv
hw/vlan_page_lookup.sv
hw/phv_vlan_tap.sv
hw/action_engine.sv
tb/action_engine_asserts.sv
tb/tb_action_engine.sv
